/* Bender.yml */
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/rv_ex_if.sv
  - src/rv_pc_reg.sv
  - src/rv_regfile.sv
  - src/rv_decoder.sv
  - src/rv_execute.sv
  - src/rv_core_top.sv
  - target: test
    files:
      - tests/rv_core_tb.sv

/* files.f */
src/rv_pkg.sv
src/rv_ex_if.sv
src/rv_pc_reg.sv
src/rv_regfile.sv
src/rv_decoder.sv
src/rv_execute.sv
src/rv_core_top.sv
tests/rv_core_tb.sv

/* src/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [rv_pkg::DATA_LEN-1:0]     inst_i,
	output logic [rv_pkg::ADDR_LEN-1:0]     pc_o,
	output logic                            invalid_o,
	output logic                            halt_o,
	output logic                            wb_en_o,
	output logic [rv_pkg::REG_ADDR_LEN-1:0] wb_addr_o,
	output logic [rv_pkg::DATA_LEN-1:0]     wb_data_o
);

	// regfile read side
	logic [rv_pkg::REG_ADDR_LEN-1:0] raddr1;
	logic [rv_pkg::REG_ADDR_LEN-1:0] raddr2;
	logic [rv_pkg::DATA_LEN-1:0]     rdata1;
	logic [rv_pkg::DATA_LEN-1:0]     rdata2;
	// writeback from execute
	logic                            wd;
	logic [rv_pkg::REG_ADDR_LEN-1:0] wreg;
	logic [rv_pkg::DATA_LEN-1:0]     wdata;
	logic [rv_pkg::ADDR_LEN-1:0]     pc_next;
	logic                            is_ebreak;

	rv_ex_if ex_bus ();

	rv_pc_reg u_pc_reg (
		.clk        (clk),
		.rst        (rst),
		.pc_next_i  (pc_next),
		.halt_req_i (is_ebreak),
		.pc_o       (pc_o),
		.halt_o     (halt_o)
	);

	rv_regfile u_regfile (
		.clk      (clk),
		.rst      (rst),
		.halt_i   (halt_o),
		.raddr1_i (raddr1),
		.raddr2_i (raddr2),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2),
		.wen_i    (wd),
		.waddr_i  (wreg),
		.wdata_i  (wdata)
	);

	rv_decoder u_decoder (
		.inst_i      (inst_i),
		.pc_i        (pc_o),
		.raddr1_o    (raddr1),
		.raddr2_o    (raddr2),
		.rdata1_i    (rdata1),
		.rdata2_i    (rdata2),
		.ex          (ex_bus.dec),
		.is_ebreak_o (is_ebreak),
		.invalid_o   (invalid_o)
	);

	rv_execute u_execute (
		.ex        (ex_bus.ex),
		.wd_o      (wd),
		.wreg_o    (wreg),
		.wdata_o   (wdata),
		.pc_next_o (pc_next)
	);

	// strobe only when a write really commits
	assign wb_en_o   = wd & rst & ~halt_o;
	assign wb_addr_o = wreg;
	assign wb_data_o = wdata;

endmodule

`default_nettype wire

/* src/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
	input  logic [rv_pkg::DATA_LEN-1:0]     inst_i,
	input  logic [rv_pkg::ADDR_LEN-1:0]     pc_i,
	output logic [rv_pkg::REG_ADDR_LEN-1:0] raddr1_o,
	output logic [rv_pkg::REG_ADDR_LEN-1:0] raddr2_o,
	input  logic [rv_pkg::DATA_LEN-1:0]     rdata1_i,
	input  logic [rv_pkg::DATA_LEN-1:0]     rdata2_i,
	rv_ex_if.dec                            ex,
	output logic                            is_ebreak_o,
	output logic                            invalid_o
);

	logic [6:0]                        opcode;
	logic [2:0]                        funct3;
	logic [6:0]                        funct7;
	logic [rv_pkg::DATA_LEN-1:0]       imm_i;
	logic [rv_pkg::DATA_LEN-1:0]       imm_u;
	logic [rv_pkg::DATA_LEN-1:0]       imm_j;
	logic [rv_pkg::DATA_LEN-1:0]       imm_b;
	logic                              legal;

	// instruction fields
	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	// sign-extended immediates
	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_u = {inst_i[31:12], 12'b0};
	assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
	assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

	// register reads go straight to the file
	assign raddr1_o = inst_i[19:15];
	assign raddr2_o = inst_i[24:20];

	// operands pass through to execute
	assign ex.pc        = pc_i;
	assign ex.reg1      = rdata1_i;
	assign ex.reg2      = rdata2_i;
	assign ex.wreg      = inst_i[11:7];
	assign ex.br_funct3 = funct3;

	assign invalid_o = ~legal;

	always_comb begin
		// defaults, reg-reg add with no write
		ex.alu_op   = rv_pkg::ALU_ADD;
		ex.src_a    = rv_pkg::SRC_A_REG;
		ex.src_b    = rv_pkg::SRC_B_REG;
		ex.wb_sel   = rv_pkg::WB_ALU;
		ex.br_kind  = rv_pkg::BR_NONE;
		ex.imm      = '0;
		ex.wd       = 1'b0;
		is_ebreak_o = 1'b0;
		legal       = 1'b0;
		case (opcode)
			rv_pkg::OPC_LUI: begin
				ex.src_a  = rv_pkg::SRC_A_ZERO;
				ex.src_b  = rv_pkg::SRC_B_IMM;
				ex.alu_op = rv_pkg::ALU_PASS_B;
				ex.imm    = imm_u;
				ex.wd     = 1'b1;
				legal     = 1'b1;
			end
			rv_pkg::OPC_AUIPC: begin
				ex.src_a = rv_pkg::SRC_A_PC;
				ex.src_b = rv_pkg::SRC_B_IMM;
				ex.imm   = imm_u;
				ex.wd    = 1'b1;
				legal    = 1'b1;
			end
			rv_pkg::OPC_JAL: begin
				ex.br_kind = rv_pkg::BR_JAL;
				ex.wb_sel  = rv_pkg::WB_PC4;
				ex.imm     = imm_j;
				ex.wd      = 1'b1;
				legal      = 1'b1;
			end
			rv_pkg::OPC_JALR: begin
				// only funct3 000 is defined
				ex.br_kind = rv_pkg::BR_JALR;
				ex.wb_sel  = rv_pkg::WB_PC4;
				ex.imm     = imm_i;
				ex.wd      = 1'b1;
				legal      = (funct3 == 3'b000);
			end
			rv_pkg::OPC_BRANCH: begin
				// 010 and 011 are reserved
				ex.br_kind = rv_pkg::BR_BRANCH;
				ex.imm     = imm_b;
				legal      = (funct3 != 3'b010) && (funct3 != 3'b011);
			end
			rv_pkg::OPC_OP_IMM: begin
				ex.src_b = rv_pkg::SRC_B_IMM;
				ex.imm   = imm_i;
				ex.wd    = 1'b1;
				legal    = 1'b1;
				case (funct3)
					3'b000: ex.alu_op = rv_pkg::ALU_ADD;
					3'b010: ex.alu_op = rv_pkg::ALU_SLT;
					3'b011: ex.alu_op = rv_pkg::ALU_SLTU;
					3'b100: ex.alu_op = rv_pkg::ALU_XOR;
					3'b110: ex.alu_op = rv_pkg::ALU_OR;
					3'b111: ex.alu_op = rv_pkg::ALU_AND;
					3'b001: begin
						ex.alu_op = rv_pkg::ALU_SLL;
						legal     = (funct7 == 7'h00);
					end
					default: begin
						// funct7 picks logical or arithmetic
						ex.alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
						legal     = (funct7 == 7'h00) || (funct7 == 7'h20);
					end
				endcase
			end
			rv_pkg::OPC_OP: begin
				ex.wd = 1'b1;
				if (funct7 == 7'h00) begin
					legal = 1'b1;
					case (funct3)
						3'b000: ex.alu_op = rv_pkg::ALU_ADD;
						3'b001: ex.alu_op = rv_pkg::ALU_SLL;
						3'b010: ex.alu_op = rv_pkg::ALU_SLT;
						3'b011: ex.alu_op = rv_pkg::ALU_SLTU;
						3'b100: ex.alu_op = rv_pkg::ALU_XOR;
						3'b101: ex.alu_op = rv_pkg::ALU_SRL;
						3'b110: ex.alu_op = rv_pkg::ALU_OR;
						default: ex.alu_op = rv_pkg::ALU_AND;
					endcase
				end else if (funct7 == 7'h20) begin
					// only sub and sra use the alt encoding
					ex.alu_op = (funct3 == 3'b000) ? rv_pkg::ALU_SUB : rv_pkg::ALU_SRA;
					legal     = (funct3 == 3'b000) || (funct3 == 3'b101);
				end
			end
			rv_pkg::OPC_SYSTEM: begin
				is_ebreak_o = (inst_i == rv_pkg::EBREAK_INST);
				legal       = is_ebreak_o;
			end
			default: begin
				legal = 1'b0;
			end
		endcase
		// illegal words retire as no-ops
		if (!legal) begin
			ex.wd      = 1'b0;
			ex.br_kind = rv_pkg::BR_NONE;
		end
	end

endmodule

`default_nettype wire

/* src/rv_ex_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface rv_ex_if;

	// control from the decoder
	rv_pkg::alu_op_e                      alu_op;
	rv_pkg::src_a_e                       src_a;
	rv_pkg::src_b_e                       src_b;
	rv_pkg::wb_sel_e                      wb_sel;
	rv_pkg::br_kind_e                     br_kind;
	logic [2:0]                           br_funct3;
	// operands
	logic [rv_pkg::ADDR_LEN-1:0]          pc;
	logic [rv_pkg::DATA_LEN-1:0]          reg1;
	logic [rv_pkg::DATA_LEN-1:0]          reg2;
	logic [rv_pkg::DATA_LEN-1:0]          imm;
	// destination register
	logic                                 wd;
	logic [rv_pkg::REG_ADDR_LEN-1:0]      wreg;

	modport dec (
		output alu_op, src_a, src_b, wb_sel, br_kind, br_funct3,
		output pc, reg1, reg2, imm, wd, wreg
	);

	modport ex (
		input alu_op, src_a, src_b, wb_sel, br_kind, br_funct3,
		input pc, reg1, reg2, imm, wd, wreg
	);

endinterface

`default_nettype wire

/* src/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
	rv_ex_if.ex                             ex,
	output logic                            wd_o,
	output logic [rv_pkg::REG_ADDR_LEN-1:0] wreg_o,
	output logic [rv_pkg::DATA_LEN-1:0]     wdata_o,
	output logic [rv_pkg::ADDR_LEN-1:0]     pc_next_o
);

	logic [rv_pkg::DATA_LEN-1:0] op_a;
	logic [rv_pkg::DATA_LEN-1:0] op_b;
	logic [rv_pkg::DATA_LEN-1:0] alu_res;
	logic [rv_pkg::DATA_LEN-1:0] jalr_sum;
	logic [rv_pkg::ADDR_LEN-1:0] pc_plus4;
	logic [rv_pkg::ADDR_LEN-1:0] pc_target;
	logic [4:0]                  shamt;
	logic                        taken;

	// operand muxes
	always_comb begin
		case (ex.src_a)
			rv_pkg::SRC_A_PC:   op_a = ex.pc;
			rv_pkg::SRC_A_ZERO: op_a = '0;
			default:            op_a = ex.reg1;
		endcase
		op_b = (ex.src_b == rv_pkg::SRC_B_IMM) ? ex.imm : ex.reg2;
	end

	assign shamt = op_b[4:0];

	// alu
	always_comb begin
		case (ex.alu_op)
			rv_pkg::ALU_SUB:    alu_res = op_a - op_b;
			rv_pkg::ALU_SLL:    alu_res = op_a << shamt;
			rv_pkg::ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
			rv_pkg::ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
			rv_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
			rv_pkg::ALU_SRL:    alu_res = op_a >> shamt;
			rv_pkg::ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
			rv_pkg::ALU_OR:     alu_res = op_a | op_b;
			rv_pkg::ALU_AND:    alu_res = op_a & op_b;
			rv_pkg::ALU_PASS_B: alu_res = op_b;
			default:            alu_res = op_a + op_b;
		endcase
	end

	// branch compare on the raw register values
	always_comb begin
		case (ex.br_funct3)
			3'b000:  taken = (ex.reg1 == ex.reg2);
			3'b001:  taken = (ex.reg1 != ex.reg2);
			3'b100:  taken = ($signed(ex.reg1) < $signed(ex.reg2));
			3'b101:  taken = ($signed(ex.reg1) >= $signed(ex.reg2));
			3'b110:  taken = (ex.reg1 < ex.reg2);
			3'b111:  taken = (ex.reg1 >= ex.reg2);
			default: taken = 1'b0;
		endcase
	end

	assign pc_plus4  = ex.pc + 32'd4;
	assign pc_target = ex.pc + ex.imm;
	// jalr drops bit 0 of the sum
	assign jalr_sum  = ex.reg1 + ex.imm;

	// next pc select
	always_comb begin
		case (ex.br_kind)
			rv_pkg::BR_BRANCH: pc_next_o = taken ? pc_target : pc_plus4;
			rv_pkg::BR_JAL:    pc_next_o = pc_target;
			rv_pkg::BR_JALR:   pc_next_o = {jalr_sum[31:1], 1'b0};
			default:           pc_next_o = pc_plus4;
		endcase
	end

	// writeback, link address for jumps
	assign wd_o    = ex.wd;
	assign wreg_o  = ex.wreg;
	assign wdata_o = (ex.wb_sel == rv_pkg::WB_PC4) ? pc_plus4 : alu_res;

endmodule

`default_nettype wire

/* src/rv_pc_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_pc_reg (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [rv_pkg::ADDR_LEN-1:0] pc_next_i,
	input  logic                        halt_req_i,
	output logic [rv_pkg::ADDR_LEN-1:0] pc_o,
	output logic                        halt_o
);

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc_o   <= rv_pkg::RESET_PC;
			halt_o <= 1'b0;
		end else if (!halt_o) begin
			// ebreak parks the pc on itself
			if (halt_req_i) begin
				halt_o <= 1'b1;
			end else begin
				pc_o <= pc_next_i;
			end
		end
		// sticky until next reset
	end

endmodule

`default_nettype wire

/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

	// datapath widths
	localparam int DATA_LEN     = 32;
	localparam int ADDR_LEN     = 32;
	localparam int REG_ADDR_LEN = 5;

	// first fetch address after reset
	localparam logic [ADDR_LEN-1:0] RESET_PC = 32'h8000_0000;

	// major opcodes, inst[6:0]
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// the only system instruction we accept
	localparam logic [31:0] EBREAK_INST = 32'h0010_0073;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {SRC_A_REG, SRC_A_PC, SRC_A_ZERO} src_a_e;

	typedef enum logic {SRC_B_REG, SRC_B_IMM} src_b_e;

	typedef enum logic {WB_ALU, WB_PC4} wb_sel_e;

	// branch condition itself travels as funct3
	typedef enum logic [1:0] {BR_NONE, BR_BRANCH, BR_JAL, BR_JALR} br_kind_e;

endpackage

`default_nettype wire

/* src/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            halt_i,
	input  logic [rv_pkg::REG_ADDR_LEN-1:0] raddr1_i,
	input  logic [rv_pkg::REG_ADDR_LEN-1:0] raddr2_i,
	output logic [rv_pkg::DATA_LEN-1:0]     rdata1_o,
	output logic [rv_pkg::DATA_LEN-1:0]     rdata2_o,
	input  logic                            wen_i,
	input  logic [rv_pkg::REG_ADDR_LEN-1:0] waddr_i,
	input  logic [rv_pkg::DATA_LEN-1:0]     wdata_i
);

	logic [rv_pkg::DATA_LEN-1:0] regs [0:31];

	// whole file clears in reset
	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen_i && !halt_i && (waddr_i != '0)) begin
			// x0 never written
			regs[waddr_i] <= wdata_i;
		end
	end

	// combinational reads, x0 hardwired
	assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

/* tests/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

	localparam int          PROG_WORDS = 128;
	localparam logic [31:0] SEED       = 32'h82f1_98ba;
	localparam logic [31:0] NOP        = 32'h0000_0013;

	logic        clk;
	logic        rst;
	logic [31:0] inst_i;
	logic [31:0] pc_o;
	logic        invalid_o;
	logic        halt_o;
	logic        wb_en_o;
	logic [4:0]  wb_addr_o;
	logic [31:0] wb_data_o;

	// program image, word 0 sits at the reset pc
	logic [31:0] prog [0:PROG_WORDS-1];
	int          prog_len;
	logic [31:0] lfsr;

	// shadow state of the reference model
	logic [31:0] m_regs [0:31];
	logic [31:0] m_pc;
	logic        m_halt;
	// predicted response of the instruction at m_pc
	logic        exp_wr;
	logic        exp_en;
	logic        exp_invalid;
	logic        exp_brk;
	logic [4:0]  exp_rd;
	logic [31:0] exp_data;
	logic [31:0] exp_next;

	logic        chk_on;
	int          value_errs;
	int          other_errs;

	rv_core_top DUT (
		.clk       (clk),
		.rst       (rst),
		.inst_i    (inst_i),
		.pc_o      (pc_o),
		.invalid_o (invalid_o),
		.halt_o    (halt_o),
		.wb_en_o   (wb_en_o),
		.wb_addr_o (wb_addr_o),
		.wb_data_o (wb_data_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// right-shift galois lfsr, one output bit per step
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		rand_bits = v;
	endfunction

	// instruction encoders
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		enc_r = {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		enc_i = {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
		enc_j = {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OPC_JAL};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		enc_b = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OPC_BRANCH};
	endfunction

	task automatic put(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	// branch over one counter increment of x10
	task automatic put_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
		put(enc_b(13'd8, rs2, rs1, f3));
		put(enc_i(12'd1, 5'd10, 3'b000, 5'd10, rv_pkg::OPC_OP_IMM));
	endtask

	task automatic build_program();
		logic        is_op;
		logic        alt;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
		prog_len = 0;
		put({20'h12345, 5'd1, rv_pkg::OPC_LUI});
		put({20'h00001, 5'd2, rv_pkg::OPC_AUIPC});
		put(enc_i(12'd5, 5'd0, 3'b000, 5'd3, rv_pkg::OPC_OP_IMM));
		put(enc_i(12'hffd, 5'd0, 3'b000, 5'd4, rv_pkg::OPC_OP_IMM));
		// jal skips one word, jalr lands past the next one with bit 0 set
		put(enc_j(21'd8, 5'd5));
		put(enc_i(12'd1, 5'd0, 3'b000, 5'd6, rv_pkg::OPC_OP_IMM));
		put({20'h00000, 5'd7, rv_pkg::OPC_AUIPC});
		put(enc_i(12'd13, 5'd7, 3'b000, 5'd8, rv_pkg::OPC_JALR));
		put(enc_i(12'd2, 5'd0, 3'b000, 5'd6, rv_pkg::OPC_OP_IMM));
		put(enc_r(7'h00, 5'd0, 5'd3, 3'b000, 5'd9));
		// write to x0, then read it back
		put(enc_i(12'd7, 5'd3, 3'b000, 5'd0, rv_pkg::OPC_OP_IMM));
		put(enc_r(7'h00, 5'd3, 5'd0, 3'b000, 5'd11));
		// x3 = 5, x4 = -3, x9 = 5; taken first, then not taken
		put_branch(3'b000, 5'd3, 5'd9);
		put_branch(3'b000, 5'd3, 5'd4);
		put_branch(3'b001, 5'd3, 5'd4);
		put_branch(3'b001, 5'd3, 5'd9);
		put_branch(3'b100, 5'd4, 5'd3);
		put_branch(3'b100, 5'd3, 5'd4);
		put_branch(3'b101, 5'd3, 5'd4);
		put_branch(3'b101, 5'd4, 5'd3);
		put_branch(3'b110, 5'd3, 5'd4);
		put_branch(3'b110, 5'd4, 5'd3);
		put_branch(3'b111, 5'd4, 5'd3);
		put_branch(3'b111, 5'd3, 5'd4);
		// random alu mix over x0..x15
		for (int n = 0; n < 40; n++) begin
			is_op = rand_bits(1);
			f3    = rand_bits(3);
			alt   = rand_bits(1);
			rd    = rand_bits(4);
			rs1   = rand_bits(4);
			if (is_op) begin
				rs2 = rand_bits(4);
				put(enc_r((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
			end else begin
				imm = rand_bits(12);
				if (f3 == 3'b001) begin
					imm = {7'h00, imm[4:0]};
				end else if (f3 == 3'b101) begin
					imm = {(alt ? 7'h20 : 7'h00), imm[4:0]};
				end
				put(enc_i(imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM));
			end
		end
		// unknown opcode, mul-style funct7, then stop
		put(32'hffff_ffff);
		put(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd12));
		put(rv_pkg::EBREAK_INST);
	endtask

	function automatic logic in_image(input logic [31:0] addr);
		logic [31:0] off;
		off      = addr - rv_pkg::RESET_PC;
		in_image = (off[1:0] == 2'b00) && ((off >> 2) < prog_len);
	endfunction

	function automatic logic [31:0] fetch(input logic [31:0] addr);
		fetch = in_image(addr) ? prog[(addr - rv_pkg::RESET_PC) >> 2] : NOP;
	endfunction

	// reference alu, alt selects sub or sra
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic signed [31:0] sa;
		sa = a;
		case (f3)
			3'b000: alu_ref = alt ? (a - b) : (a + b);
			3'b001: alu_ref = a << b[4:0];
			3'b010: alu_ref = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: alu_ref = (a < b) ? 32'd1 : 32'd0;
			3'b100: alu_ref = a ^ b;
			3'b101: begin
				if (alt) begin
					alu_ref = sa >>> b[4:0];
				end else begin
					alu_ref = a >> b[4:0];
				end
			end
			3'b110: alu_ref = a | b;
			default: alu_ref = a & b;
		endcase
	endfunction

	task automatic predict(input logic [31:0] inst);
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic        bad;
		logic        take;
		f3       = inst[14:12];
		f7       = inst[31:25];
		a        = m_regs[inst[19:15]];
		b        = m_regs[inst[24:20]];
		imm_i    = $signed(inst[31:20]);
		imm_b    = $signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0});
		imm_j    = $signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0});
		exp_rd   = inst[11:7];
		exp_wr   = 1'b0;
		exp_data = '0;
		exp_next = m_pc + 32'd4;
		exp_brk  = 1'b0;
		bad      = 1'b0;
		take     = 1'b0;
		case (inst[6:0])
			rv_pkg::OPC_LUI: begin
				exp_wr   = 1'b1;
				exp_data = {inst[31:12], 12'h000};
			end
			rv_pkg::OPC_AUIPC: begin
				exp_wr   = 1'b1;
				exp_data = m_pc + {inst[31:12], 12'h000};
			end
			rv_pkg::OPC_JAL: begin
				exp_wr   = 1'b1;
				exp_data = m_pc + 32'd4;
				exp_next = m_pc + imm_j;
			end
			rv_pkg::OPC_JALR: begin
				bad      = (f3 != 3'b000);
				exp_wr   = 1'b1;
				exp_data = m_pc + 32'd4;
				exp_next = (a + imm_i) & ~32'h1;
			end
			rv_pkg::OPC_BRANCH: begin
				case (f3)
					3'b000: take = (a == b);
					3'b001: take = (a != b);
					3'b100: take = ($signed(a) < $signed(b));
					3'b101: take = ($signed(a) >= $signed(b));
					3'b110: take = (a < b);
					3'b111: take = (a >= b);
					default: bad = 1'b1;
				endcase
				if (take) begin
					exp_next = m_pc + imm_b;
				end
			end
			rv_pkg::OPC_OP_IMM: begin
				bad      = (f3 == 3'b001 && f7 != 7'h00) ||
					(f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
				exp_wr   = 1'b1;
				exp_data = alu_ref(f3, (f3 == 3'b101) && f7[5], a, imm_i);
			end
			rv_pkg::OPC_OP: begin
				bad      = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
				exp_wr   = 1'b1;
				exp_data = alu_ref(f3, f7[5], a, b);
			end
			rv_pkg::OPC_SYSTEM: begin
				exp_brk = (inst == rv_pkg::EBREAK_INST);
				bad     = !exp_brk;
			end
			default: bad = 1'b1;
		endcase
		// unknown words retire as no-ops
		if (bad) begin
			exp_wr   = 1'b0;
			exp_next = m_pc + 32'd4;
		end
		exp_invalid = bad;
		exp_en      = exp_wr && rst && !m_halt;
	endtask

	// falling edge, fetch for the DUT and predict from the shadow state
	task automatic drive_cycle();
		logic [31:0] word;
		word = fetch(pc_o);
		// a halted core gets a writing word that it has to ignore
		if (m_halt) begin
			word = enc_i(12'd1, 5'd1, 3'b000, 5'd1, rv_pkg::OPC_OP_IMM);
		end
		inst_i = word;
		if (rst && !in_image(pc_o)) begin
			other_errs++;
			$display("pc_o %h points outside the program image", pc_o);
		end
		if (m_halt) begin
			predict(word);
		end else begin
			predict(fetch(m_pc));
		end
	endtask

	// model retires on the rising edge
	always @(posedge clk) begin
		if (!rst) begin
			m_pc   <= rv_pkg::RESET_PC;
			m_halt <= 1'b0;
			for (int i = 0; i < 32; i++) begin
				m_regs[i] <= '0;
			end
		end else if (!m_halt) begin
			if (exp_brk) begin
				m_halt <= 1'b1;
			end else begin
				m_pc <= exp_next;
			end
			if (exp_wr && exp_rd != 5'd0) begin
				m_regs[exp_rd] <= exp_data;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!chk_on) pc_o == m_pc)
	else begin
		value_errs++;
		$display("[FAIL] pc_o: got %h, expected %h", $sampled(pc_o), $sampled(m_pc));
	end

	assert property (@(posedge clk) disable iff (!chk_on) halt_o == m_halt)
	else begin
		value_errs++;
		$display("[FAIL] halt_o: got %h, expected %h", $sampled(halt_o), $sampled(m_halt));
	end

	assert property (@(posedge clk) disable iff (!chk_on) invalid_o == exp_invalid)
	else begin
		value_errs++;
		$display("[FAIL] invalid_o: got %h, expected %h", $sampled(invalid_o),
			$sampled(exp_invalid));
	end

	assert property (@(posedge clk) disable iff (!chk_on) wb_en_o == exp_en)
	else begin
		value_errs++;
		$display("[FAIL] wb_en_o: got %h, expected %h", $sampled(wb_en_o), $sampled(exp_en));
	end

	// address and data also while a write is suppressed
	assert property (@(posedge clk) disable iff (!chk_on) exp_wr |-> wb_addr_o == exp_rd)
	else begin
		value_errs++;
		$display("[FAIL] wb_addr_o: got %h, expected %h", $sampled(wb_addr_o), $sampled(exp_rd));
	end

	assert property (@(posedge clk) disable iff (!chk_on) exp_wr |-> wb_data_o == exp_data)
	else begin
		value_errs++;
		$display("[FAIL] wb_data_o: got %h, expected %h", $sampled(wb_data_o),
			$sampled(exp_data));
	end

	// once halted the pc is frozen and nothing writes back
	assert property (@(posedge clk) disable iff (!chk_on) halt_o |=> $stable(pc_o))
	else begin
		value_errs++;
		$display("[FAIL] pc_o: moved to %h while halted", $sampled(pc_o));
	end

	assert property (@(posedge clk) disable iff (!chk_on) halt_o |-> !wb_en_o)
	else begin
		value_errs++;
		$display("[FAIL] wb_en_o: got %h while halted, expected 0", $sampled(wb_en_o));
	end

	initial begin
		int limit_ns;
		#1;
		limit_ns = (prog_len + 50) * 4;
		#(limit_ns);
		$display("timeout: the core did not reach ebreak within %0d ns", limit_ns);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		rst         = 1'b0;
		inst_i      = '0;
		chk_on      = 1'b0;
		value_errs  = 0;
		other_errs  = 0;
		exp_wr      = 1'b0;
		exp_en      = 1'b0;
		exp_brk     = 1'b0;
		exp_invalid = 1'b0;
		lfsr        = SEED;
		build_program();
		// eight rising edges with rst low
		repeat (7) begin
			@(negedge clk);
			chk_on = 1'b1;
			drive_cycle();
		end
		@(negedge clk);
		rst = 1'b1;
		drive_cycle();
		while (!m_halt) begin
			@(negedge clk);
			drive_cycle();
		end
		repeat (6) begin
			@(negedge clk);
			drive_cycle();
		end
		$display("summary: %0d value mismatches, %0d other errors", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
